// File: sim.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/instr_fifo.sv
verilog/prefetch_queue.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/mini_core.sv
tests/mini_core_checker.sv
tests/mini_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the mini core testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mini_core_tb -f sim.f \
        > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vmini_core_tb > sim.log 2>&1
cat sim.log

grep -qx "Finished with no errors" sim.log && echo "Simulation passed" && exit 0 \
        || { echo "Simulation failed"; exit 1; }

// File: tests/mini_core_tb.sv
// Mini core testbench with directed and random programs checked by a reference model
`default_nettype none
`timescale 1ns/1ps

module mini_core_tb;

        import isa_pkg::*;
        import pipe_pkg::*;

        localparam int FIFO_DEPTH   = 8;
        localparam int CLK_HALF     = 50;
        localparam int DRIVE_DELAY  = 5;
        localparam int TOTAL_INSTR  = 68;
        localparam int DRAIN_LIMIT  = 400;
        localparam int WATCHDOG_CYC = TOTAL_INSTR * 20 + 200;

        logic    i_clk;
        logic    i_reset;
        instr_t  i_instr;
        logic    i_valid;
        logic    i_hold;
        logic    i_flush;
        logic    o_full;
        retire_t o_retire;

        // Architectural register state as the program order sees it
        data_t   model_regs [REG_COUNT];
        retire_t exp_q [$];
        opcode_e alu_ops [5] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_MUL};
        int      errors;
        int      checks;
        int      tests;

        mini_core #(
                .FIFO_DEPTH (FIFO_DEPTH)
        ) i_mini_core (
                .i_clk    (i_clk),
                .i_reset  (i_reset),
                .i_instr  (i_instr),
                .i_valid  (i_valid),
                .i_hold   (i_hold),
                .i_flush  (i_flush),
                .o_full   (o_full),
                .o_retire (o_retire)
        );

        initial
        begin
                i_clk = 1'b0;
                forever #CLK_HALF i_clk = ~i_clk;
        end

        // -------------------------------------------------------------------------
        // Reference model and encoders
        // -------------------------------------------------------------------------

        // Fields are taken straight from the 16-bit word; unknown codes never retire
        function automatic retire_t ref_exec(input data_t regs [REG_COUNT], input instr_t ins);
                logic [15:0] bits;
                data_t       a;
                data_t       b;
                retire_t     r;
                begin
                        bits    = ins;
                        a       = regs[bits[3:2]];
                        b       = regs[bits[1:0]];
                        r.valid = 1'b1;
                        r.rd    = bits[11:10];
                        case (bits[15:12])
                                OP_LDI:  r.value = bits[7:0];
                                OP_ADD:  r.value = a + b;
                                OP_SUB:  r.value = a - b;
                                OP_AND:  r.value = a & b;
                                OP_XOR:  r.value = a ^ b;
                                // Products wrap to the low byte
                                OP_MUL:  r.value = a * b;
                                default: r = '0;
                        endcase
                        return r;
                end
        endfunction

        function automatic instr_t make_alu(input opcode_e op, input reg_idx_t rd,
                                            input reg_idx_t rs1, input reg_idx_t rs2);
                return instr_t'({op, rd, 2'b00, 4'b0000, rs1, rs2});
        endfunction

        function automatic instr_t make_ldi(input reg_idx_t rd, input data_t imm);
                return instr_t'({OP_LDI, rd, 2'b00, imm});
        endfunction

        // -------------------------------------------------------------------------
        // Compare tasks and retire monitor
        // -------------------------------------------------------------------------

        task automatic compare_retire(input retire_t got, input retire_t exp);
                begin
                        checks++;
                        if (got !== exp)
                        begin
                                errors++;
                                $display("** Error: o_retire = %h, expected %h at %0t",
                                         got, exp, $time);
                        end
                end
        endtask

        task automatic compare_full(input logic got, input logic exp);
                begin
                        checks++;
                        if (got !== exp)
                        begin
                                errors++;
                                $display("** Error: o_full = %h, expected %h at %0t",
                                         got, exp, $time);
                        end
                end
        endtask

        // Each retire pops the oldest expected entry in program order
        always @(negedge i_clk)
        begin
                if (!i_reset && o_retire.valid)
                begin
                        if (exp_q.size() == 0)
                        begin
                                errors++;
                                $display("Unexpected retire of r%0d with value %h at %0t",
                                         o_retire.rd, o_retire.value, $time);
                        end
                        else
                        begin
                                compare_retire(o_retire, exp_q.pop_front());
                        end
                end
        end

        // -------------------------------------------------------------------------
        // Stimulus helpers that start and end just after a rising edge
        // -------------------------------------------------------------------------

        task automatic idle_cycles(input int n);
                begin
                        repeat (n) @(posedge i_clk);
                        #DRIVE_DELAY;
                end
        endtask

        task automatic write_cycle(input instr_t ins);
                begin
                        i_instr = ins;
                        i_valid = 1'b1;
                        idle_cycles(1);
                        i_valid = 1'b0;
                end
        endtask

        // The full flag seen before the edge decides whether this write lands
        task automatic drive_instr(input instr_t ins, input bit retry, output bit accepted);
                retire_t exp;
                begin
                        while (retry && o_full)
                                idle_cycles(1);
                        accepted = !o_full;
                        if (accepted)
                        begin
                                exp = ref_exec(model_regs, ins);
                                if (exp.valid)
                                begin
                                        model_regs[exp.rd] = exp.value;
                                        exp_q.push_back(exp);
                                end
                        end
                        write_cycle(ins);
                end
        endtask

        // Wait for every expected retire, then let bubbles and NOPs drain out
        task automatic wait_retires();
                int cycles;
                begin
                        cycles = 0;
                        while (exp_q.size() != 0 && cycles < DRAIN_LIMIT)
                        begin
                                idle_cycles(1);
                                cycles++;
                        end
                        if (exp_q.size() != 0)
                        begin
                                errors++;
                                $display("%0d expected retires never arrived", exp_q.size());
                                exp_q.delete();
                        end
                        idle_cycles(4);
                end
        endtask

        task automatic end_test(input string name, input int errs_before);
                begin
                        tests++;
                        $display("Test %0d %s: %s", tests, name,
                                 (errors == errs_before) ? "ok" : "FAILED");
                end
        endtask

        // -------------------------------------------------------------------------
        // Test sequence
        // -------------------------------------------------------------------------

        initial
        begin
                bit       acc;
                int       k;
                int       errs0;
                int       taken;
                opcode_e  op;
                reg_idx_t rd;
                reg_idx_t rs2;
                reg_idx_t prev_rd;
                void'($urandom(46));
                i_reset = 1'b1;
                i_instr = '0;
                i_valid = 1'b0;
                i_hold  = 1'b0;
                i_flush = 1'b0;
                errors  = 0;
                checks  = 0;
                tests   = 0;
                for (k = 0; k < REG_COUNT; k++)
                        model_regs[k] = '0;
                repeat (4) @(posedge i_clk);
                #DRIVE_DELAY;
                i_reset = 1'b0;
                compare_full(o_full, 1'b0);

                // Load every register with a distinct immediate
                errs0 = errors;
                for (k = 0; k < REG_COUNT; k++)
                        drive_instr(make_ldi(reg_idx_t'(k), data_t'(8'h12 + 8'h22 * k)), 1'b1, acc);
                wait_retires();
                end_test("load immediates", errs0);

                // Each instruction reads the register its predecessor wrote
                errs0   = errors;
                prev_rd = 2'd3;
                for (k = 0; k < 40; k++)
                begin
                        op  = alu_ops[$urandom_range(4, 0)];
                        rd  = reg_idx_t'($urandom_range(3, 0));
                        rs2 = reg_idx_t'($urandom_range(3, 0));
                        drive_instr(make_alu(op, rd, prev_rd, rs2), 1'b1, acc);
                        prev_rd = rd;
                end
                wait_retires();
                end_test("random dependent ALU and MUL", errs0);

                // With the pipeline frozen the FIFO fills and the surplus writes are lost
                errs0  = errors;
                taken  = 0;
                i_hold = 1'b1;
                for (k = 0; k < FIFO_DEPTH + 3; k++)
                begin
                        compare_full(o_full, taken == FIFO_DEPTH);
                        if (k % 3 == 2)
                                drive_instr(make_alu(OP_ADD, reg_idx_t'(k), reg_idx_t'(k - 1),
                                                     reg_idx_t'(k - 2)), 1'b0, acc);
                        else
                                drive_instr(make_ldi(reg_idx_t'(k), data_t'(8'h80 + k)), 1'b0, acc);
                        if (acc)
                                taken++;
                end
                compare_full(o_full, 1'b1);
                i_hold = 1'b0;
                wait_retires();
                compare_full(o_full, 1'b0);
                end_test("back-pressure", errs0);

                // A flushed batch must leave no trace in the register file
                errs0  = errors;
                i_hold = 1'b1;
                for (k = 0; k < 5; k++)
                        write_cycle(make_ldi(reg_idx_t'(k), data_t'(8'he0 + k)));
                i_flush = 1'b1;
                idle_cycles(1);
                i_flush = 1'b0;
                i_hold  = 1'b0;
                idle_cycles(12);
                compare_full(o_full, 1'b0);
                drive_instr(make_ldi(2'd1, 8'h21), 1'b1, acc);
                drive_instr(make_alu(OP_ADD, 2'd2, 2'd1, 2'd0), 1'b1, acc);
                wait_retires();
                end_test("flush", errs0);

                // NOP and unknown codes slip through without a retire
                errs0 = errors;
                drive_instr(make_ldi(2'd0, 8'h0f), 1'b1, acc);
                drive_instr(instr_t'(16'h00ff), 1'b1, acc);
                drive_instr(instr_t'(16'hb0ff), 1'b1, acc);
                drive_instr(make_alu(OP_ADD, 2'd1, 2'd0, 2'd0), 1'b1, acc);
                drive_instr(instr_t'(16'hf4aa), 1'b1, acc);
                drive_instr(make_alu(OP_XOR, 2'd2, 2'd1, 2'd0), 1'b1, acc);
                wait_retires();
                end_test("NOP and undefined opcodes", errs0);

                $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
                if (errors == 0)
                        $display("Finished with no errors");
                else
                        $display("Finished with errors");
                $finish;
        end

        // Budget of twenty cycles per instruction plus setup
        initial
        begin
                repeat (WATCHDOG_CYC) @(posedge i_clk);
                $display("Watchdog expired after %0d cycles", WATCHDOG_CYC);
                $display("Finished with errors");
                $finish;
        end

endmodule

`default_nettype wire

// File: tests/mini_core_checker.sv
// Concurrent assertions on the mini core's reset behavior, FIFO clear and multiply stall
`default_nettype none
`timescale 1ns/1ps

module mini_core_checker (
        input  logic               i_clk,
        input  logic               i_reset,
        input  logic               i_flush,
        input  logic               i_full,
        input  pipe_pkg::retire_t  i_retire,
        input  logic               i_fifo_empty_n,
        input  logic               i_exec_stall
);

        // Every reset edge leaves the retire port and the full flag quiet
        a_reset_quiet: assert property (@(posedge i_clk) i_reset |=> !i_retire.valid && !i_full)
                else $error("retire valid or full flag seen in the cycle after a reset edge");

        // A clear empties the buffer, so the full flag is low in the next cycle too
        a_clear_empty: assert property (@(posedge i_clk) disable iff (i_reset)
                i_flush |=> !i_fifo_empty_n && !i_full)
                else $error("instruction FIFO not empty or still full after a flush");

        // The multiply holds decode for exactly one extra cycle
        a_stall_single: assert property (@(posedge i_clk) disable iff (i_reset)
                i_exec_stall |=> !i_exec_stall)
                else $error("execute stall held for more than one cycle");

endmodule

bind mini_core mini_core_checker u_mini_core_checker (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_flush        (i_flush),
        .i_full         (o_full),
        .i_retire       (o_retire),
        .i_fifo_empty_n (u_prefetch_queue.fifo_valid),
        .i_exec_stall   (exec_stall)
);

`default_nettype wire

// File: verilog/mini_core.sv
// Mini core top level: prefetch queue followed by decode, execute and result
`default_nettype none
`timescale 1ns/1ps

module mini_core #(
        parameter int FIFO_DEPTH = 8
) (
        input  logic               i_clk,
        input  logic               i_reset,
        input  isa_pkg::instr_t    i_instr,
        input  logic               i_valid,
        input  logic               i_hold,
        input  logic               i_flush,
        output logic               o_full,
        output pipe_pkg::retire_t  o_retire
);

        import isa_pkg::*;
        import pipe_pkg::*;

        ctrl_t    ctrl;
        logic     exec_stall;
        logic     decode_stall;
        instr_t   q_instr;
        logic     q_valid;
        reg_idx_t rs1;
        reg_idx_t rs2;
        data_t    rd1;
        data_t    rd2;
        dec_out_t dec;
        exe_out_t exe;
        exe_out_t res_busy;

        // External clear and freeze first, then the stage stalls
        assign ctrl = '{flush: i_flush, hold: i_hold, exec_stall: exec_stall,
                        decode_stall: decode_stall};

        prefetch_queue #(
                .FIFO_DEPTH (FIFO_DEPTH)
        ) u_prefetch_queue (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .i_ctrl  (ctrl),
                .i_instr (i_instr),
                .i_valid (i_valid),
                .o_instr (q_instr),
                .o_valid (q_valid),
                .o_full  (o_full)
        );

        decode_stage u_decode_stage (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_flush        (i_flush),
                .i_hold         (i_hold),
                .i_instr        (q_instr),
                .i_valid        (q_valid),
                .o_rs1          (rs1),
                .o_rs2          (rs2),
                .i_rd1          (rd1),
                .i_rd2          (rd2),
                .i_exe_busy     (exe),
                .i_res_busy     (res_busy),
                .i_exec_stall   (exec_stall),
                .o_decode_stall (decode_stall),
                .o_dec          (dec)
        );

        execute_stage u_execute_stage (
                .i_clk        (i_clk),
                .i_reset      (i_reset),
                .i_hold       (i_hold),
                .i_dec        (dec),
                .o_exec_stall (exec_stall),
                .o_exe        (exe)
        );

        result_stage u_result_stage (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_exe      (exe),
                .i_rs1      (rs1),
                .i_rs2      (rs2),
                .o_rd1      (rd1),
                .o_rd2      (rd2),
                .o_res_busy (res_busy),
                .o_retire   (o_retire)
        );

endmodule

`default_nettype wire

// File: verilog/result_stage.sv
// Result stage with the register file, writeback and the retire report
`default_nettype none
`timescale 1ns/1ps

module result_stage (
        input  logic                i_clk,
        input  logic                i_reset,
        input  pipe_pkg::exe_out_t  i_exe,
        input  isa_pkg::reg_idx_t   i_rs1,
        input  isa_pkg::reg_idx_t   i_rs2,
        output isa_pkg::data_t      o_rd1,
        output isa_pkg::data_t      o_rd2,
        output pipe_pkg::exe_out_t  o_res_busy,
        output pipe_pkg::retire_t   o_retire
);

        import isa_pkg::*;
        import pipe_pkg::*;

        data_t    regs [REG_COUNT];
        exe_out_t res_q;

        // Result register; each valid entry lives here for exactly one cycle
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        res_q.valid <= 1'b0;
                else
                        res_q <= i_exe;
        end

        // Register file commits the retiring entry at the end of its cycle
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int i = 0; i < REG_COUNT; i++)
                                regs[i] <= '0;
                end
                else if (res_q.valid)
                begin
                        regs[res_q.rd] <= res_q.value;
                end
        end

        // Combinational read ports used by decode
        assign o_rd1 = regs[i_rs1];
        assign o_rd2 = regs[i_rs2];

        // Decode treats the entry here as a hazard until the register file holds it
        assign o_res_busy = res_q;
        assign o_retire   = res_q;

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
// Execute stage with a single-cycle ALU and a multiply split over two cycles
`default_nettype none
`timescale 1ns/1ps

module execute_stage (
        input  logic                i_clk,
        input  logic                i_reset,
        input  logic                i_hold,
        input  pipe_pkg::dec_out_t  i_dec,
        output logic                o_exec_stall,
        output pipe_pkg::exe_out_t  o_exe
);

        import isa_pkg::*;

        typedef enum logic {
                IDLE     = 1'b0,
                MUL_WAIT = 1'b1
        } state_e;

        state_e state;
        data_t  alu_result;
        data_t  mul_lo;
        data_t  mul_hi;
        data_t  mul_partial;

        // ------------------------------------------------------------------------
        // Datapath with every result modulo 256
        // ------------------------------------------------------------------------

        always_comb
        begin
                case (i_dec.op)
                        OP_LDI:  alu_result = i_dec.operand_a;
                        OP_ADD:  alu_result = i_dec.operand_a + i_dec.operand_b;
                        OP_SUB:  alu_result = i_dec.operand_a - i_dec.operand_b;
                        OP_AND:  alu_result = i_dec.operand_a & i_dec.operand_b;
                        OP_XOR:  alu_result = i_dec.operand_a ^ i_dec.operand_b;
                        default: alu_result = '0;
                endcase
        end

        // First cycle takes the low nibble of B, second adds the high nibble
        assign mul_lo = i_dec.operand_a * {4'b0000, i_dec.operand_b[3:0]};
        assign mul_hi = i_dec.operand_a * {4'b0000, i_dec.operand_b[7:4]};

        // Decode keeps the MUL in place for the one extra cycle
        assign o_exec_stall = (state == IDLE) && i_dec.valid && (i_dec.op == OP_MUL) && !i_hold;

        // ------------------------------------------------------------------------
        // Control and output register
        // ------------------------------------------------------------------------

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state       <= IDLE;
                        o_exe.valid <= 1'b0;
                end
                else if (i_hold)
                begin
                        // The result stage must not see a repeat while frozen
                        o_exe.valid <= 1'b0;
                end
                else if (state == MUL_WAIT)
                begin
                        // A flush in the first cycle leaves no valid MUL here
                        o_exe.valid <= i_dec.valid;
                        o_exe.rd    <= i_dec.rd;
                        o_exe.value <= mul_partial + {mul_hi[3:0], 4'b0000};
                        state       <= IDLE;
                end
                else if (o_exec_stall)
                begin
                        mul_partial <= mul_lo;
                        o_exe.valid <= 1'b0;
                        state       <= MUL_WAIT;
                end
                else
                begin
                        o_exe.valid <= i_dec.valid && (i_dec.op != OP_NOP);
                        o_exe.rd    <= i_dec.rd;
                        o_exe.value <= alu_result;
                end
        end

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
// Decode stage with operand read and read-after-write hazard detection
`default_nettype none
`timescale 1ns/1ps

module decode_stage (
        input  logic                i_clk,
        input  logic                i_reset,
        input  logic                i_flush,
        input  logic                i_hold,
        input  isa_pkg::instr_t     i_instr,
        input  logic                i_valid,
        output isa_pkg::reg_idx_t   o_rs1,
        output isa_pkg::reg_idx_t   o_rs2,
        input  isa_pkg::data_t      i_rd1,
        input  isa_pkg::data_t      i_rd2,
        input  pipe_pkg::exe_out_t  i_exe_busy,
        input  pipe_pkg::exe_out_t  i_res_busy,
        input  logic                i_exec_stall,
        output logic                o_decode_stall,
        output pipe_pkg::dec_out_t  o_dec
);

        import isa_pkg::*;
        import pipe_pkg::*;

        opcode_e  dec_op;
        logic     uses_regs;
        logic     own_hit;
        logic     exe_hit;
        logic     res_hit;
        dec_out_t next_dec;

        // Undefined codes collapse to NOP so later stages see only legal ops
        always_comb
        begin
                case (i_instr.opcode)
                        OP_LDI, OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_MUL:
                                dec_op = i_instr.opcode;
                        default:
                                dec_op = OP_NOP;
                endcase
        end

        // LDI and NOP read nothing, so they never wait on a hazard
        assign uses_regs = dec_op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_MUL};

        assign o_rs1 = i_instr.operand.src.rs1;
        assign o_rs2 = i_instr.operand.src.rs2;

        // Own register is the op in execute; the two busy ports have not
        // reached the register file yet
        assign own_hit = o_dec.valid && (o_dec.op != OP_NOP)
                         && (o_dec.rd == o_rs1 || o_dec.rd == o_rs2);
        assign exe_hit = i_exe_busy.valid && (i_exe_busy.rd == o_rs1 || i_exe_busy.rd == o_rs2);
        assign res_hit = i_res_busy.valid && (i_res_busy.rd == o_rs1 || i_res_busy.rd == o_rs2);

        assign o_decode_stall = i_valid && uses_regs && (own_hit || exe_hit || res_hit);

        always_comb
        begin
                next_dec.valid     = i_valid;
                next_dec.op        = dec_op;
                next_dec.rd        = i_instr.rd;
                // Immediate rides in operand A for LDI
                next_dec.operand_a = (dec_op == OP_LDI) ? i_instr.operand.imm : i_rd1;
                next_dec.operand_b = i_rd2;
        end

        // Hold and a busy multiplier keep the register; a hazard sends a bubble
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        o_dec.valid <= 1'b0;
                end
                else if (!i_hold && !i_exec_stall)
                begin
                        if (o_decode_stall)
                                o_dec.valid <= 1'b0;
                        else
                                o_dec <= next_dec;
                end
        end

endmodule

`default_nettype wire

// File: verilog/prefetch_queue.sv
// Prefetch instruction queue with prioritized clear and stall handling
`default_nettype none
`timescale 1ns/1ps

module prefetch_queue #(
        parameter int FIFO_DEPTH = 8
) (
        input  logic             i_clk,
        input  logic             i_reset,
        input  pipe_pkg::ctrl_t  i_ctrl,
        input  isa_pkg::instr_t  i_instr,
        input  logic             i_valid,
        output isa_pkg::instr_t  o_instr,
        output logic             o_valid,
        output logic             o_full
);

        import isa_pkg::*;

        logic   clear;
        logic   rd_en;
        logic   wr_en;
        logic   fifo_valid;
        instr_t fifo_instr;

        // ------------------------------------------------------------------------
        // Priority resolution
        // ------------------------------------------------------------------------

        // Only a flush clears; every lower request is a stall
        assign clear = i_ctrl.flush;

        // The queue advances when nothing downstream asks it to wait
        assign rd_en = !i_ctrl.flush && !i_ctrl.hold && !i_ctrl.exec_stall
                       && !i_ctrl.decode_stall;

        // Writes are inhibited while full or while the queue is being emptied
        assign wr_en = i_valid && !o_full && !clear;

        instr_fifo #(
                .WIDTH ($bits(instr_t)),
                .DEPTH (FIFO_DEPTH)
        ) u_instr_fifo (
                .i_clk     (i_clk),
                .i_reset   (i_reset),
                .i_clear   (clear),
                .i_wr_en   (wr_en),
                .i_rd_en   (rd_en),
                .i_data    (i_instr),
                .o_data    (fifo_instr),
                .o_empty_n (fifo_valid),
                .o_full    (o_full)
        );

        // ------------------------------------------------------------------------
        // Output pipeline register
        // ------------------------------------------------------------------------

        // A stall keeps the register as it is; an empty FIFO loads a bubble
        always_ff @(posedge i_clk)
        begin
                if (i_reset || clear)
                begin
                        o_valid <= 1'b0;
                end
                else if (rd_en)
                begin
                        o_valid <= fifo_valid;
                        o_instr <= fifo_instr;
                end
        end

endmodule

`default_nettype wire

// File: verilog/instr_fifo.sv
// Synchronous circular buffer with show-ahead output and full and empty flags
`default_nettype none
`timescale 1ns/1ps

module instr_fifo #(
        parameter int WIDTH = 16,
        parameter int DEPTH = 8
) (
        input  logic             i_clk,
        input  logic             i_reset,
        input  logic             i_clear,
        input  logic             i_wr_en,
        input  logic             i_rd_en,
        input  logic [WIDTH-1:0] i_data,
        output logic [WIDTH-1:0] o_data,
        output logic             o_empty_n,
        output logic             o_full
);

        localparam int AW = $clog2(DEPTH);

        // Entry storage
        logic [WIDTH-1:0] mem [DEPTH];

        // One extra bit above the index marks a lap of the buffer
        logic [AW:0] wr_ptr;
        logic [AW:0] rd_ptr;
        logic        wr_ok;
        logic        rd_ok;

        // Equal pointers mean empty; equal indices on different laps mean full
        assign o_empty_n = (wr_ptr != rd_ptr);
        assign o_full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

        // Requests that would overflow or underflow are ignored
        assign wr_ok = i_wr_en && !o_full;
        assign rd_ok = i_rd_en && o_empty_n;

        // Oldest entry is always visible
        assign o_data = mem[rd_ptr[AW-1:0]];

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end
                else
                begin
                        if (wr_ok)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (rd_ok)
                                rd_ptr <= rd_ptr + 1'b1;
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (wr_ok)
                        mem[wr_ptr[AW-1:0]] <= i_data;
        end

endmodule

`default_nettype wire

// File: verilog/pipe_pkg.sv
// Pipeline control bits and the payloads passed between core stages
`default_nettype none

package pipe_pkg;

        // Stall and clear requests seen by the prefetch queue
        typedef struct packed {
                logic flush;
                logic hold;
                logic exec_stall;
                logic decode_stall;
        } ctrl_t;

        // Decode to execute
        typedef struct packed {
                logic             valid;
                isa_pkg::opcode_e op;
                isa_pkg::reg_idx_t rd;
                isa_pkg::data_t   operand_a;
                isa_pkg::data_t   operand_b;
        } dec_out_t;

        // Execute to result
        typedef struct packed {
                logic              valid;
                isa_pkg::reg_idx_t rd;
                isa_pkg::data_t    value;
        } exe_out_t;

        // Retire report carries the same fields as the execute result
        typedef exe_out_t retire_t;

endpackage

`default_nettype wire

// File: verilog/isa_pkg.sv
// Instruction set of the mini core: opcodes, instruction layout and data types
`default_nettype none

package isa_pkg;

        // Register file size and datapath width
        parameter int REG_COUNT = 4;
        parameter int DATA_W    = 8;

        typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;
        typedef logic [DATA_W-1:0]            data_t;

        // Any code outside this list decodes as OP_NOP
        typedef enum logic [3:0] {
                OP_NOP = 4'd0,
                OP_LDI = 4'd1,
                OP_ADD = 4'd2,
                OP_SUB = 4'd3,
                OP_AND = 4'd4,
                OP_XOR = 4'd5,
                OP_MUL = 4'd6
        } opcode_e;

        // Register reading of the low operand byte
        typedef struct packed {
                logic [DATA_W-2*$clog2(REG_COUNT)-1:0] rsvd;
                reg_idx_t                             rs1;
                reg_idx_t                             rs2;
        } reg_src_t;

        // The opcode decides whether the byte is an immediate or two sources
        typedef union packed {
                data_t    imm;
                reg_src_t src;
        } operand_u;

        // 16-bit instruction word
        typedef struct packed {
                opcode_e    opcode;
                reg_idx_t   rd;
                logic [1:0] rsvd;
                operand_u   operand;
        } instr_t;

endpackage

`default_nettype wire
